//--- all.f
+incdir+include
hdl/l1_cache_pkg.sv
hdl/addr_decode.sv
hdl/line_array.sv
hdl/cache_controller.sv
hdl/proc_response.sv
hdl/l1_cache.sv
test/clock_gen.sv
test/l1_cache_sva.sv
test/tb_l1_cache.sv

//--- hdl/addr_decode.sv
/* decode stage: address split, tag compare against the read line,
   non-cacheable region check and victim writeback address */
`default_nettype none
`include "l1_params.svh"

module addr_decode
    import l1_cache_pkg::*;
(
    input  word_t         addr,
    input  line_t         line,
    output decoded_addr_t dec,
    output logic          hit,
    output logic          pass_through,
    output logic          victim_dirty,
    output word_t         victim_addr
);

    logic tag_match;

    assign dec = decoded_addr_t'(addr);

    // uncached region starts at a fixed address
    assign pass_through = (addr >= word_t'(`L1_NONCACHE_START));

    assign tag_match = (line.tag == dec.tag);

    // never a hit in the uncached region
    assign hit = !pass_through && line.valid && tag_match;

    // stored line must go back to memory before it is replaced
    assign victim_dirty = line.valid && line.dirty;

    // word-aligned address of the stored line
    assign victim_addr = {line.tag, dec.idx, 2'b00};

endmodule

`default_nettype wire

//--- hdl/cache_controller.sv
/* execute stage: cache FSM, INIT/FLUSH set walk, flush latch,
   line array writes, memory requests and processor hold */
`default_nettype none
`include "l1_params.svh"

module cache_controller
    import l1_cache_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,
    input  logic          flush,
    input  proc_req_t     req,
    input  mem_rsp_t      mem_rsp,
    input  decoded_addr_t dec,
    input  logic          hit,
    input  logic          pass_through,
    input  logic          victim_dirty,
    input  word_t         victim_addr,
    input  line_t         rline,
    input  word_t         store_word,
    output logic          flush_done,
    output mem_req_t      mem_req,
    output set_idx_t      idx,
    output logic          we,
    output line_t         wline,
    output rsp_sel_t      rsp_sel
);

    cache_state_t state;
    cache_state_t next_state;

    // set walk shared by INIT and FLUSH
    set_idx_t walk_idx;
    logic     walk_step;
    logic     walk_last;

    logic flush_req;
    logic flush_pend;
    logic access;

    assign walk_last  = (walk_idx == set_idx_t'(`L1_N_SETS - 1));
    assign flush_pend = flush || flush_req;
    assign access     = req.ren || req.wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= INIT;
            walk_idx  <= '0;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            if (walk_step) begin
                walk_idx <= walk_idx + 1'b1;
            end
            // READY always serves a pending flush
            if (state == READY) begin
                flush_req <= 1'b0;
            end else if (flush) begin
                flush_req <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state      = state;
        idx             = dec.idx;
        we              = 1'b0;
        wline           = rline;
        mem_req         = '0;
        mem_req.byte_en = '1;
        rsp_sel         = RSP_HOLD;
        walk_step       = 1'b0;
        flush_done      = 1'b0;

        case (state)
            INIT: begin
                // one set cleared per cycle
                idx       = walk_idx;
                we        = 1'b1;
                wline     = '0;
                walk_step = 1'b1;
                if (walk_last) begin
                    flush_done = 1'b1;
                    next_state = READY;
                end
            end

            READY: begin
                if (flush_pend) begin
                    next_state = FLUSH;
                end else if (access && pass_through) begin
                    // forward as is, response mirrors memory
                    mem_req.ren     = req.ren;
                    mem_req.wen     = req.wen;
                    mem_req.addr    = req.addr;
                    mem_req.wdata   = req.wdata;
                    mem_req.byte_en = req.byte_en;
                    rsp_sel         = RSP_MEM;
                end else if (access && hit) begin
                    if (req.wen) begin
                        we          = 1'b1;
                        wline.dirty = 1'b1;
                        wline.data  = store_word;
                        rsp_sel     = RSP_STORE;
                    end else begin
                        rsp_sel = RSP_HIT;
                    end
                end else if (access) begin
                    next_state = victim_dirty ? WRITEBACK : FETCH;
                end
            end

            WRITEBACK: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = victim_addr;
                mem_req.wdata = rline.data;
                if (!mem_rsp.busy) begin
                    // line stays valid but clean until the fill
                    we          = 1'b1;
                    wline.dirty = 1'b0;
                    next_state  = FETCH;
                end
            end

            FETCH: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {dec.tag, dec.idx, 2'b00};
                rsp_sel      = RSP_MEM;
                // access completes with the fill
                if (!mem_rsp.busy) begin
                    we          = 1'b1;
                    wline.valid = 1'b1;
                    wline.dirty = req.wen;
                    wline.tag   = dec.tag;
                    wline.data  = req.wen ? store_word : mem_rsp.rdata;
                    next_state  = READY;
                end
            end

            FLUSH: begin
                idx = walk_idx;
                if (rline.valid && rline.dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = {rline.tag, walk_idx, 2'b00};
                    mem_req.wdata = rline.data;
                    walk_step     = !mem_rsp.busy;
                end else begin
                    walk_step = 1'b1;
                end
                // invalidate each set as the walk leaves it
                we    = walk_step;
                wline = '0;
                if (walk_step && walk_last) begin
                    flush_done = 1'b1;
                    next_state = READY;
                end
            end

            default: begin
                next_state = INIT;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/l1_cache.sv
/* L1 data cache top: decode, line array, controller and
   result stage, plus the outgoing memory request */
`default_nettype none

module l1_cache
    import l1_cache_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      flush,
    output logic      flush_done,
    input  proc_req_t proc_req,
    output proc_rsp_t proc_rsp,
    output mem_req_t  mem_req,
    input  mem_rsp_t  mem_rsp
);

    decoded_addr_t dec;
    logic          hit;
    logic          pass_through;
    logic          victim_dirty;
    word_t         victim_addr;
    set_idx_t      idx;
    logic          we;
    line_t         wline;
    line_t         rline;
    rsp_sel_t      rsp_sel;
    word_t         store_word;
    word_t         pass_wdata;
    mem_req_t      ctrl_mem_req;

    addr_decode u_decode (
        .addr         (proc_req.addr),
        .line         (rline),
        .dec          (dec),
        .hit          (hit),
        .pass_through (pass_through),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr)
    );

    line_array u_lines (
        .CLK   (CLK),
        .idx   (idx),
        .we    (we),
        .wline (wline),
        .rline (rline)
    );

    cache_controller u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .req          (proc_req),
        .mem_rsp      (mem_rsp),
        .dec          (dec),
        .hit          (hit),
        .pass_through (pass_through),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .rline        (rline),
        .store_word   (store_word),
        .flush_done   (flush_done),
        .mem_req      (ctrl_mem_req),
        .idx          (idx),
        .we           (we),
        .wline        (wline),
        .rsp_sel      (rsp_sel)
    );

    proc_response u_rsp (
        .req        (proc_req),
        .rsel       (rsp_sel),
        .rline      (rline),
        .mem_rsp    (mem_rsp),
        .rsp        (proc_rsp),
        .store_word (store_word),
        .pass_wdata (pass_wdata)
    );

    // forwarded uncached stores take the lane-zeroed data
    always_comb begin
        mem_req = ctrl_mem_req;
        if ((rsp_sel == RSP_MEM) && pass_through) begin
            mem_req.wdata = pass_wdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/l1_cache_pkg.sv
/* L1 cache types: width typedefs, address and line layout,
   processor and memory bus structs, FSM and response select enums */
`default_nettype none
`include "l1_params.svh"

package l1_cache_pkg;

    localparam int SET_W = $clog2(`L1_N_SETS);
    localparam int TAG_W = `L1_WORD_W - SET_W - 2;

    typedef logic [`L1_WORD_W-1:0] word_t;
    typedef logic [3:0]            byte_en_t;
    typedef logic [SET_W-1:0]      set_idx_t;
    typedef logic [TAG_W-1:0]      tag_t;

    // processor address split, one word wide
    typedef struct packed {
        tag_t       tag;
        set_idx_t   idx;
        logic [1:0] offset;
    } decoded_addr_t;

    // one stored line
    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        word_t data;
    } line_t;

    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } proc_rsp_t;

    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        INIT,
        READY,
        FETCH,
        WRITEBACK,
        FLUSH
    } cache_state_t;

    // which answer the result stage gives the processor
    typedef enum logic [1:0] {
        RSP_HOLD,
        RSP_HIT,
        RSP_STORE,
        RSP_MEM
    } rsp_sel_t;

endpackage

`default_nettype wire

//--- hdl/line_array.sv
/* line storage: tag, valid, dirty and data per set,
   combinational read and rising-edge write */
`default_nettype none
`include "l1_params.svh"

module line_array
    import l1_cache_pkg::*;
(
    input  logic     CLK,
    input  set_idx_t idx,
    input  logic     we,
    input  line_t    wline,
    output line_t    rline
);

    // contents come up unknown, the INIT walk clears them
    line_t lines [`L1_N_SETS];

    // read port follows the index in the same cycle
    assign rline = lines[idx];

    always_ff @(posedge CLK) begin
        if (we) begin
            lines[idx] <= wline;
        end
    end

endmodule

`default_nettype wire

//--- hdl/proc_response.sv
/* result stage: store lane merge, pass-through store data
   and processor response select */
`default_nettype none

module proc_response
    import l1_cache_pkg::*;
(
    input  proc_req_t req,
    input  rsp_sel_t  rsel,
    input  line_t     rline,
    input  mem_rsp_t  mem_rsp,
    output proc_rsp_t rsp,
    output word_t     store_word,
    output word_t     pass_wdata
);

    word_t base_word;
    word_t lane_mask;

    // fetched word while filling, stored word otherwise
    assign base_word = (rsel == RSP_MEM) ? mem_rsp.rdata : rline.data;

    always_comb begin
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            lane_mask[i*8 +: 8] = {8{req.byte_en[i]}};
        end
    end

    assign store_word = (req.wdata & lane_mask) | (base_word & ~lane_mask);

    // uncached stores carry zero outside the enabled lanes
    assign pass_wdata = req.wdata & lane_mask;

    always_comb begin
        case (rsel)
            RSP_HIT: begin
                rsp.busy  = 1'b0;
                rsp.rdata = rline.data;
            end
            RSP_STORE: begin
                rsp.busy  = 1'b0;
                rsp.rdata = '0;
            end
            RSP_MEM: begin
                rsp.busy  = mem_rsp.busy;
                rsp.rdata = mem_rsp.rdata;
            end
            default: begin
                rsp.busy  = 1'b1;
                rsp.rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- include/l1_params.svh
/* L1 data cache build constants
   word width, number of lines, start of the non-cacheable region */
`ifndef L1_PARAMS_SVH
`define L1_PARAMS_SVH

// data and address width in bits
`define L1_WORD_W 32

// number of lines, must be a power of two
`define L1_N_SETS 16

// addresses at or above this bypass the cache
`define L1_NONCACHE_START 32'hF000_0000

`endif

//--- run.sh
#!/bin/sh
# build and run the L1 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l1_cache -f all.f -o sim_l1_cache
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_l1_cache +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- test/clock_gen.sv
/* testbench clock of period 10 and 16-cycle active-low reset */
`default_nettype none

module clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        #1 nRST = 1'b1;
    end

    always #5 CLK = ~CLK;

endmodule

`default_nettype wire

//--- test/l1_cache_sva.sv
/* memory port protocol assertions, bound into the cache controller */
`default_nettype none

module l1_cache_sva
    import l1_cache_pkg::*;
(
    input logic     CLK,
    input logic     nRST,
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp,
    input logic     flush_done
);

    int unsigned fail_count = 0;

    // request held while memory is busy
    req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req))
    else begin
        fail_count++;
        $error("CHECK FAILED at %0t: memory request changed while busy", $time);
    end

    no_read_write: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
    else begin
        fail_count++;
        $error("CHECK FAILED at %0t: memory ren and wen both high", $time);
    end

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
    else begin
        fail_count++;
        $error("CHECK FAILED at %0t: flush_done high two cycles in a row", $time);
    end

endmodule

`default_nettype wire

//--- test/tb_l1_cache.sv
/* L1 cache testbench with memory model, shadow memory, reset, random,
   hit latency and flush tests, timeout and final result */
`default_nettype none
`include "l1_params.svh"

module tb_l1_cache
    import l1_cache_pkg::*;
();

    localparam int N_RANDOM   = 300;
    localparam int N_ACCESSES = N_RANDOM + 40;
    localparam int TIMEOUT    = 200 * N_ACCESSES + 40 * `L1_N_SETS;

    logic      CLK;
    logic      nRST;
    logic      flush;
    logic      flush_done;
    proc_req_t proc_req;
    proc_rsp_t proc_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;

    word_t mem_words [word_t];
    word_t shadow [word_t];
    word_t written [$];
    int    wait_cnt;
    int    errors;
    int    tests_passed;
    int    tests_failed;
    int    cycle_cnt;

    clock_gen clk0 (.CLK(CLK), .nRST(nRST));

    l1_cache dut0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (flush_done),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    bind cache_controller l1_cache_sva sva0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush_done (flush_done)
    );

    // initial memory contents derived from every address bit
    function automatic word_t fill_word(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic word_t lane_mask(input byte_en_t be);
        word_t m;
        for (int i = 0; i < 4; i++) begin
            m[i*8 +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    function automatic word_t mem_word(input word_t a);
        word_t aw;
        aw = a & ~word_t'(3);
        return mem_words.exists(aw) ? mem_words[aw] : fill_word(aw);
    endfunction

    function automatic word_t shadow_word(input word_t a);
        word_t aw;
        aw = a & ~word_t'(3);
        return shadow.exists(aw) ? shadow[aw] : fill_word(aw);
    endfunction

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // memory model sees completion and writes at the falling edge
    always @(negedge CLK) begin
        if (nRST && (mem_req.ren || mem_req.wen)) begin
            if (!mem_rsp.busy) begin
                if (mem_req.wen) begin
                    if (mem_req.addr < `L1_NONCACHE_START) begin
                        check(mem_req.addr[1:0] == 2'b00, "writeback address not aligned");
                        check(mem_req.wdata == shadow_word(mem_req.addr),
                              $sformatf("writeback to %h carries %h, expected %h",
                                        mem_req.addr, mem_req.wdata,
                                        shadow_word(mem_req.addr)));
                    end
                    mem_words[mem_req.addr & ~word_t'(3)] =
                        (mem_word(mem_req.addr) & ~lane_mask(mem_req.byte_en))
                        | (mem_req.wdata & lane_mask(mem_req.byte_en));
                end
                wait_cnt = $urandom_range(3, 0);
            end else if (wait_cnt > 0) begin
                wait_cnt--;
            end
        end
    end

    always @(posedge CLK) begin
        #2;
        mem_rsp.busy  = (mem_req.ren || mem_req.wen) && (wait_cnt != 0);
        mem_rsp.rdata = mem_word(mem_req.addr);
    end

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("timeout: run exceeded %0d cycles", TIMEOUT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // one access entered 1 unit after a rising edge and left the same way
    task automatic do_access(input logic wr, input word_t a, input word_t d,
                             input byte_en_t be, output int cycles, output logic fetched);
        logic pass;
        word_t m;
        pass    = (a >= `L1_NONCACHE_START);
        m       = lane_mask(be);
        cycles  = 0;
        fetched = 1'b0;
        proc_req.ren     = !wr;
        proc_req.wen     = wr;
        proc_req.addr    = a;
        proc_req.wdata   = d;
        proc_req.byte_en = be;
        forever begin
            @(negedge CLK);
            cycles++;
            if (mem_req.ren) begin
                fetched = 1'b1;
            end
            if (pass) begin
                check(mem_req.addr == a && mem_req.ren == !wr && mem_req.wen == wr,
                      "pass-through request not forwarded");
                if (wr) begin
                    check(mem_req.wdata == (d & m), "pass-through store lanes not zeroed");
                    check(mem_req.byte_en == be, "pass-through store enables not forwarded");
                end
            end
            if (!proc_rsp.busy) begin
                break;
            end
        end
        if (wr) begin
            shadow[a & ~word_t'(3)] = (shadow_word(a) & ~m) | (d & m);
            if (!pass) begin
                written.push_back(a);
            end
        end else begin
            check(proc_rsp.rdata == shadow_word(a),
                  $sformatf("read %h returned %h, expected %h",
                            a, proc_rsp.rdata, shadow_word(a)));
        end
        @(posedge CLK);
        #1 proc_req = '0;
    endtask

    // byte offset varies so that word alignment on the memory side matters
    function automatic word_t pick_addr(input logic allow_pass);
        set_idx_t   s;
        tag_t       t;
        logic [1:0] off;
        s   = set_idx_t'($urandom_range(3, 0));
        t   = ($urandom_range(1, 0) != 0) ? tag_t'('h0A5) : tag_t'('h13C);
        off = 2'($urandom_range(3, 0));
        if (allow_pass && $urandom_range(7, 0) == 0) begin
            return `L1_NONCACHE_START + {s, off};
        end
        return {t, s, off};
    endfunction

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int       e0;
        int       cycles;
        int       done_cnt;
        int       sva_fails;
        logic     fetched;
        word_t    a;
        byte_en_t be;

        proc_req  = '0;
        mem_rsp   = '0;
        flush     = 1'b0;
        wait_cnt  = 0;
        errors    = 0;
        cycle_cnt = 0;
        void'($urandom(32'h2019));

        // reset and INIT walk of fixed length
        e0 = errors;
        done_cnt = 0;
        while (!nRST) begin
            @(negedge CLK);
            check(proc_rsp.busy && !flush_done, "busy low or done high in reset");
        end
        repeat (`L1_N_SETS + 8) begin
            @(negedge CLK);
            check(proc_rsp.busy, "proc busy low during start-up");
            check(!mem_req.ren && !mem_req.wen, "memory request during start-up");
            if (flush_done) begin
                done_cnt++;
            end
        end
        check(done_cnt == 1, $sformatf("flush_done pulsed %0d times at start-up", done_cnt));
        @(posedge CLK);
        #1;
        report_test("reset", e0);

        e0 = errors;
        repeat (N_RANDOM) begin
            be = byte_en_t'($urandom_range(15, 0));
            if (be == '0) begin
                be = '1;
            end
            do_access($urandom_range(1, 0) != 0, pick_addr(1'b1), $urandom(), be,
                      cycles, fetched);
        end
        report_test("random", e0);

        e0 = errors;
        repeat (8) begin
            a = pick_addr(1'b0);
            do_access(1'b0, a, '0, '1, cycles, fetched);
            do_access(1'b0, a, '0, '1, cycles, fetched);
            check(cycles == 1, $sformatf("repeat read of %h took %0d cycles", a, cycles));
        end
        report_test("hit_latency", e0);

        e0 = errors;
        flush = 1'b1;
        @(posedge CLK);
        #1 flush = 1'b0;
        do begin
            @(negedge CLK);
        end while (!flush_done);
        @(posedge CLK);
        #1;
        foreach (written[i]) begin
            check(mem_word(written[i]) == shadow_word(written[i]),
                  $sformatf("memory at %h stale after flush", written[i]));
        end
        if (written.size() > 0) begin
            do_access(1'b0, written[0], '0, '1, cycles, fetched);
            check(fetched, "read after flush did not fetch from memory");
        end
        report_test("flush", e0);

        sva_fails = dut0.u_ctrl.sva0.fail_count;
        $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, sva_fails);
        if (tests_failed == 0 && sva_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
